/* src/eq_pkg.sv */
// Shared widths, frame states and helper functions for the one-tap equalizer.
// Modules use scoped names in their headers and a wildcard import in the body.

package eq_pkg;

  // --------------------
  // Sample format
  // --------------------

  // Packed complex sample, I in the upper half and Q in the lower half
  localparam int SAMPLE_W = 32;
  localparam int COMP_W   = 16;

  // Subcarriers per OFDM symbol, fixed by the training table below
  localparam int N_SC = 64;

  // --------------------
  // Frame control
  // --------------------

  typedef enum logic [1:0] {
    ST_TRAIN    = 2'd0,
    ST_EQUALIZE = 2'd1,
    ST_IDLE     = 2'd2
  } frame_state_e;

  // 802.11 long training symbol, bit k belongs to subcarrier k
  // Nonzero mask marks used subcarriers, negative mask marks the -1 entries
  localparam logic [N_SC-1:0] TRAIN_NZ  = 64'h07FF_FFFE_FFFF_FFC0;
  localparam logic [N_SC-1:0] TRAIN_NEG = 64'h0056_7D4C_0A60_5300;

  // --------------------
  // Functions
  // --------------------

  // Known sign of a training subcarrier: -1, 0 or +1
  function automatic logic signed [1:0] train_sign(input logic [$clog2(N_SC)-1:0] idx);
    logic signed [1:0] s;
    if (!TRAIN_NZ[idx]) begin
      s = 2'sd0;
    end else if (TRAIN_NEG[idx]) begin
      s = -2'sd1;
    end else begin
      s = 2'sd1;
    end
    return s;
  endfunction

  // Negate one component, most negative value clips to the positive limit
  function automatic logic signed [COMP_W-1:0] sat_neg(input logic signed [COMP_W-1:0] x);
    logic signed [COMP_W-1:0] r;
    if (x == {1'b1, {(COMP_W-1){1'b0}}}) begin
      r = {1'b0, {(COMP_W-1){1'b1}}};
    end else begin
      r = -x;
    end
    return r;
  endfunction

endpackage

/* src/channel_estimator.sv */
// Channel estimator: detects start of frame, captures the training symbol
// into a weight memory and replays the weights while data symbols arrive.
`timescale 1ns/1ns

module channel_estimator (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        i_sof,
  // Input stream from the top level
  input  logic [eq_pkg::SAMPLE_W-1:0] i_tdata,
  input  logic                        i_tvalid,
  output logic                        o_tready,
  // Data samples forwarded to the symbol buffer
  output logic                        o_buf_valid,
  input  logic                        i_buf_ready,
  // Frame restart for buffer and combiner
  output logic                        o_flush,
  // Weight stream to the combiner
  output logic [eq_pkg::SAMPLE_W-1:0] o_w_data,
  output logic                        o_w_valid,
  input  logic                        i_w_ready
);

  import eq_pkg::*;

  localparam int IDX_W = $clog2(N_SC);

  // --------------------
  // Declarations
  // --------------------

  frame_state_e state;

  logic             sof_q;
  logic             sof_edge;
  logic [IDX_W-1:0] train_cnt;
  logic [IDX_W-1:0] w_idx;
  logic             train_acc;

  // One weight per subcarrier
  logic [SAMPLE_W-1:0] wmem [N_SC];

  logic signed [1:0]        sign;
  logic signed [COMP_W-1:0] t_i;
  logic signed [COMP_W-1:0] t_q;
  logic signed [COMP_W-1:0] w_i;
  logic signed [COMP_W-1:0] w_q;

  // --------------------
  // Frame control
  // --------------------

  // Rising edge of sof starts a new frame
  assign sof_edge = i_sof & ~sof_q;
  assign o_flush  = sof_edge;

  // Training samples are taken here and never reach the buffer
  assign train_acc = (state == ST_TRAIN) && i_tvalid && !sof_edge;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state     <= ST_IDLE;
      sof_q     <= 1'b0;
      train_cnt <= '0;
      w_idx     <= '0;
    end else begin
      sof_q <= i_sof;
      if (sof_edge) begin
        state     <= ST_TRAIN;
        train_cnt <= '0;
        w_idx     <= '0;
      end else begin
        if (train_acc) begin
          train_cnt <= train_cnt + IDX_W'(1);
          // Last training write and state change on the same edge
          if (train_cnt == IDX_W'(N_SC - 1)) begin
            state <= ST_EQUALIZE;
          end
        end
        // Replay index wraps after the last subcarrier
        if (o_w_valid && i_w_ready) begin
          w_idx <= w_idx + IDX_W'(1);
        end
      end
    end
  end

  // --------------------
  // Weight calculation
  // --------------------

  assign sign = train_sign(train_cnt);
  assign t_i  = i_tdata[SAMPLE_W-1:COMP_W];
  assign t_q  = i_tdata[COMP_W-1:0];

  // conj(sign * sample), null subcarriers give zero
  always_comb begin
    w_i = '0;
    w_q = '0;
    if (sign == 2'sd1) begin
      w_i = t_i;
      w_q = sat_neg(t_q);
    end else if (sign == -2'sd1) begin
      w_i = sat_neg(t_i);
      w_q = sat_neg(sat_neg(t_q));
    end
  end

  always_ff @(posedge clk_i) begin
    if (train_acc) begin
      wmem[train_cnt] <= {w_i, w_q};
    end
  end

  // --------------------
  // Stream routing
  // --------------------

  // Input is blocked on the sof edge cycle and while idle
  always_comb begin
    case (state)
      ST_TRAIN:    o_tready = !sof_edge;
      ST_EQUALIZE: o_tready = i_buf_ready && !sof_edge;
      default:     o_tready = 1'b0;
    endcase
  end

  assign o_buf_valid = (state == ST_EQUALIZE) && i_tvalid && !sof_edge;

  assign o_w_valid = (state == ST_EQUALIZE);
  assign o_w_data  = wmem[w_idx];

endmodule

/* src/symbol_buffer.sv */
// Circular FIFO that holds data samples and their last flag until the
// combiner pairs them with a weight. Flush empties it at a new frame.
`timescale 1ns/1ns

module symbol_buffer #(
  parameter int BUF_DEPTH = 16
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        i_flush,
  // Write side
  input  logic [eq_pkg::SAMPLE_W-1:0] i_data,
  input  logic                        i_last,
  input  logic                        i_valid,
  output logic                        o_ready,
  // Read side
  output logic [eq_pkg::SAMPLE_W-1:0] o_d_data,
  output logic                        o_d_last,
  output logic                        o_d_valid,
  input  logic                        i_d_ready
);

  import eq_pkg::*;

  localparam int PTR_W = $clog2(BUF_DEPTH);
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);
  localparam int WORD_W = SAMPLE_W + 1;

  // Last flag stored in the top bit
  logic [WORD_W-1:0] mem [BUF_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign o_ready   = (count != CNT_W'(BUF_DEPTH));
  assign o_d_valid = (count != '0);
  assign push      = i_valid && o_ready;
  assign pop       = o_d_valid && i_d_ready;

  // Head of the queue is visible without a read delay
  assign {o_d_last, o_d_data} = mem[rd_ptr];

  // --------------------
  // Pointers and count
  // --------------------

  always_ff @(posedge clk_i) begin
    if (rst_i || i_flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= {i_last, i_data};
    end
  end

endmodule

/* src/weight_combiner.sv */
// Pairs each data sample with its subcarrier weight, multiplies them and
// rounds, shifts and saturates the product back to 16-bit I and Q.
`timescale 1ns/1ns

module weight_combiner #(
  parameter int OUT_SHIFT = 15
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        i_flush,
  // Weight stream
  input  logic [eq_pkg::SAMPLE_W-1:0] i_w_data,
  input  logic                        i_w_valid,
  output logic                        o_w_ready,
  // Data stream from the buffer
  input  logic [eq_pkg::SAMPLE_W-1:0] i_d_data,
  input  logic                        i_d_last,
  input  logic                        i_d_valid,
  output logic                        o_d_ready,
  // Equalized output
  output logic [eq_pkg::SAMPLE_W-1:0] o_data,
  output logic                        o_last,
  output logic                        o_valid,
  input  logic                        i_out_ready
);

  import eq_pkg::*;

  localparam int PROD_W = 2 * COMP_W + 1;
  localparam int RND_W  = PROD_W + 1;

  localparam logic signed [RND_W-1:0] HALF_LSB = RND_W'(1) <<< (OUT_SHIFT - 1);
  localparam logic signed [RND_W-1:0] SAT_MAX  = RND_W'(2 ** (COMP_W - 1) - 1);
  localparam logic signed [RND_W-1:0] SAT_MIN  = -RND_W'(2 ** (COMP_W - 1));

  // Round half up, shift and clip one component
  function automatic logic [COMP_W-1:0] rnd_sat(input logic signed [PROD_W-1:0] v);
    logic signed [RND_W-1:0] r;
    r = (RND_W'(v) + HALF_LSB) >>> OUT_SHIFT;
    if (r > SAT_MAX) begin
      r = SAT_MAX;
    end else if (r < SAT_MIN) begin
      r = SAT_MIN;
    end
    return r[COMP_W-1:0];
  endfunction

  logic signed [COMP_W-1:0]   d_i, d_q, w_i, w_q;
  logic signed [2*COMP_W-1:0] p_ii, p_qq, p_iq, p_qi;

  logic                     s1_valid, s1_last, s1_ready;
  logic signed [PROD_W-1:0] s1_re, s1_im;
  logic                     s2_ready;
  logic                     pair_fire;

  // --------------------
  // Handshake
  // --------------------

  assign s2_ready  = !o_valid || i_out_ready;
  assign s1_ready  = !s1_valid || s2_ready;
  assign pair_fire = i_w_valid && i_d_valid && s1_ready;
  assign o_w_ready = i_d_valid && s1_ready;
  assign o_d_ready = i_w_valid && s1_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i || i_flush) begin
      s1_valid <= 1'b0;
      o_valid  <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid <= pair_fire;
      end
      if (s2_ready) begin
        o_valid <= s1_valid;
      end
    end
  end

  // --------------------
  // Stage 1, complex multiply
  // --------------------

  assign d_i = i_d_data[SAMPLE_W-1:COMP_W];
  assign d_q = i_d_data[COMP_W-1:0];
  assign w_i = i_w_data[SAMPLE_W-1:COMP_W];
  assign w_q = i_w_data[COMP_W-1:0];

  assign p_ii = (2*COMP_W)'(d_i) * (2*COMP_W)'(w_i);
  assign p_qq = (2*COMP_W)'(d_q) * (2*COMP_W)'(w_q);
  assign p_iq = (2*COMP_W)'(d_i) * (2*COMP_W)'(w_q);
  assign p_qi = (2*COMP_W)'(d_q) * (2*COMP_W)'(w_i);

  always_ff @(posedge clk_i) begin
    if (pair_fire) begin
      s1_re   <= PROD_W'(p_ii) - PROD_W'(p_qq);
      s1_im   <= PROD_W'(p_iq) + PROD_W'(p_qi);
      s1_last <= i_d_last;
    end
    // Stage 2, round and saturate
    if (s1_valid && s2_ready) begin
      o_data <= {rnd_sat(s1_re), rnd_sat(s1_im)};
      o_last <= s1_last;
    end
  end

endmodule

/* src/one_tap_equalizer.sv */
// One-tap frequency-domain equalizer for 64-subcarrier OFDM frames.
// Estimator and buffer run side by side, the combiner merges their streams.
`timescale 1ns/1ns

module one_tap_equalizer #(
  parameter int OUT_SHIFT = 15,
  parameter int BUF_DEPTH = 16
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        i_sof,
  // Received subcarrier stream
  input  logic [eq_pkg::SAMPLE_W-1:0] i_tdata,
  input  logic                        i_tlast,
  input  logic                        i_tvalid,
  output logic                        o_tready,
  // Equalized stream
  output logic [eq_pkg::SAMPLE_W-1:0] o_tdata,
  output logic                        o_tlast,
  output logic                        o_tvalid,
  input  logic                        i_out_ready
);

  logic                        flush;
  logic                        buf_valid;
  logic                        buf_ready;
  logic [eq_pkg::SAMPLE_W-1:0] w_data;
  logic                        w_valid;
  logic                        w_ready;
  logic [eq_pkg::SAMPLE_W-1:0] d_data;
  logic                        d_last;
  logic                        d_valid;
  logic                        d_ready;

  channel_estimator u_estimator (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .i_sof       (i_sof),
    .i_tdata     (i_tdata),
    .i_tvalid    (i_tvalid),
    .o_tready    (o_tready),
    .o_buf_valid (buf_valid),
    .i_buf_ready (buf_ready),
    .o_flush     (flush),
    .o_w_data    (w_data),
    .o_w_valid   (w_valid),
    .i_w_ready   (w_ready)
  );

  // Data samples only, training never reaches here
  symbol_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_buffer (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .i_flush   (flush),
    .i_data    (i_tdata),
    .i_last    (i_tlast),
    .i_valid   (buf_valid),
    .o_ready   (buf_ready),
    .o_d_data  (d_data),
    .o_d_last  (d_last),
    .o_d_valid (d_valid),
    .i_d_ready (d_ready)
  );

  weight_combiner #(
    .OUT_SHIFT (OUT_SHIFT)
  ) u_combiner (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .i_flush     (flush),
    .i_w_data    (w_data),
    .i_w_valid   (w_valid),
    .o_w_ready   (w_ready),
    .i_d_data    (d_data),
    .i_d_last    (d_last),
    .i_d_valid   (d_valid),
    .o_d_ready   (d_ready),
    .o_data      (o_tdata),
    .o_last      (o_tlast),
    .o_valid     (o_tvalid),
    .i_out_ready (i_out_ready)
  );

endmodule

/* bench/one_tap_equalizer_sva.sv */
// Protocol assertions for the equalizer top level, attached with bind.
// Covers reset state, output stability under stall and the sof response.
`timescale 1ns/1ns

module one_tap_equalizer_sva (
  input logic                        clk_i,
  input logic                        rst_i,
  input logic                        i_sof,
  input logic [eq_pkg::SAMPLE_W-1:0] o_tdata,
  input logic                        o_tlast,
  input logic                        o_tvalid,
  input logic                        o_tready,
  input logic                        i_out_ready,
  input eq_pkg::frame_state_e        est_state
);

  import eq_pkg::*;

  // Failed assertions so far
  int fail_count = 0;

  // Both handshakes quiet right after reset
  a_reset_quiet: assert property (@(posedge clk_i)
    rst_i |=> (!o_tvalid && !o_tready))
    else begin
      fail_count++;
      $error("o_tvalid or o_tready high after reset");
    end

  // Held output unless a new frame flushes the pipeline
  a_stall_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (o_tvalid && !i_out_ready && !(i_sof && !$past(i_sof)))
      |=> (o_tvalid && $stable(o_tdata) && $stable(o_tlast)))
    else begin
      fail_count++;
      $error("Output changed while stalled");
    end

  a_sof_train: assert property (@(posedge clk_i) disable iff (rst_i)
    (i_sof && !$past(i_sof)) |=> (est_state == ST_TRAIN))
    else begin
      fail_count++;
      $error("Estimator not in training after sof edge");
    end

endmodule

bind one_tap_equalizer one_tap_equalizer_sva u_sva (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .i_sof       (i_sof),
  .o_tdata     (o_tdata),
  .o_tlast     (o_tlast),
  .o_tvalid    (o_tvalid),
  .o_tready    (o_tready),
  .i_out_ready (i_out_ready),
  .est_state   (u_estimator.state)
);

/* include/eq_ref_model.svh */
// Reference model functions for the equalizer testbench: training signs,
// per-subcarrier weights and the expected equalized sample.
`ifndef EQ_REF_MODEL_SVH
`define EQ_REF_MODEL_SVH

// 802.11 long training signs, one character per subcarrier
function automatic int ref_sign(input int k);
  string pat;
  pat = {"000000++--++-+-+", "+++++--++-+-++++", "0+--++-+-+-----+", "+--+-+-++++00000"};
  if (pat[k] == "+") return 1;
  if (pat[k] == "-") return -1;
  return 0;
endfunction

function automatic longint ref_neg(input longint x);
  return (x == -32768) ? 32767 : -x;
endfunction

// conj(sign * training sample) with clipped negation
function automatic logic [31:0] ref_weight(input logic [31:0] t, input int k);
  longint ti;
  longint tq;
  int     s;
  ti = $signed(t[31:16]);
  tq = $signed(t[15:0]);
  s  = ref_sign(k);
  if (s == 0) return 32'h0;
  if (s == 1) return {16'(ti), 16'(ref_neg(tq))};
  return {16'(ref_neg(ti)), 16'(ref_neg(ref_neg(tq)))};
endfunction

function automatic logic [15:0] ref_round(input longint v, input int shift);
  longint r;
  r = (v + (longint'(1) <<< (shift - 1))) >>> shift;
  if (r > 32767) r = 32767;
  if (r < -32768) r = -32768;
  return 16'(r);
endfunction

// Expected output for one data sample and its weight
function automatic logic [31:0] ref_equalize(input logic [31:0] d, input logic [31:0] w,
                                             input int shift);
  longint di, dq, wi, wq;
  di = $signed(d[31:16]);
  dq = $signed(d[15:0]);
  wi = $signed(w[31:16]);
  wq = $signed(w[15:0]);
  return {ref_round(di * wi - dq * wq, shift), ref_round(di * wq + dq * wi, shift)};
endfunction

`endif

/* bench/tb_one_tap_equalizer.sv */
// Testbench for the one-tap equalizer with random and full-scale frames,
// output stalls and a frame restart, checked against the reference model.
`timescale 1ns/1ns

module tb_one_tap_equalizer;

  import eq_pkg::*;

  `include "eq_ref_model.svh"

  localparam int OUT_SHIFT = 15;
  localparam int BUF_DEPTH = 16;
  localparam int TIMEOUT   = 2000;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        i_sof;
  logic [31:0] i_tdata;
  logic        i_tlast;
  logic        i_tvalid;
  logic        o_tready;
  logic [31:0] o_tdata;
  logic        o_tlast;
  logic        o_tvalid;
  logic        i_out_ready;

  integer      seed = 32'h4031_0415;
  int          errors = 0;
  int          timeouts = 0;
  logic [31:0] weights [64];
  logic [32:0] exp_q [$];
  int          in_idx = 0;
  int          frame_data = 0;
  int          frame_out = 0;
  logic        sof_prev = 1'b0;
  logic        check_idle = 1'b0;
  logic        stall_en = 1'b0;

  one_tap_equalizer #(
    .OUT_SHIFT (OUT_SHIFT),
    .BUF_DEPTH (BUF_DEPTH)
  ) dut0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .i_sof       (i_sof),
    .i_tdata     (i_tdata),
    .i_tlast     (i_tlast),
    .i_tvalid    (i_tvalid),
    .o_tready    (o_tready),
    .o_tdata     (o_tdata),
    .o_tlast     (o_tlast),
    .o_tvalid    (o_tvalid),
    .i_out_ready (i_out_ready)
  );

  always #4 clk_i = ~clk_i;

  // Random downstream stalls drawn at the clock edge
  always @(posedge clk_i) begin
    logic stall;
    stall = 1'b0;
    if (stall_en) begin
      stall = (($random(seed) % 3) == 0);
    end
    #1;
    i_out_ready <= !stall;
  end

  // --------------------
  // Model and scoreboard
  // --------------------

  always @(posedge clk_i) begin
    logic [32:0] exp;
    if (!rst_i) begin
      if (o_tvalid && i_out_ready) begin
        frame_out++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Output at %0t with no pending data sample", $time);
        end else begin
          exp = exp_q.pop_front();
          assert ({o_tlast, o_tdata} == exp)
          else begin
            errors++;
            $display("Fail at %0t: output %h last %b, expected %h last %b",
                     $time, o_tdata, o_tlast, exp[31:0], exp[32]);
          end
        end
      end
      if (check_idle) begin
        assert (!o_tready && !o_tvalid)
        else begin
          errors++;
          $display("Fail at %0t: handshake active before any sof", $time);
        end
      end
      // Input blocked while equalizing only with a full buffer
      if (dut0.u_estimator.state == ST_EQUALIZE && !o_tready && !(i_sof && !sof_prev)) begin
        assert (dut0.u_buffer.count == BUF_DEPTH)
        else begin
          errors++;
          $display("Fail at %0t: o_tready low with buffer not full", $time);
        end
      end
      if (i_sof && !sof_prev) begin
        exp_q.delete();
        in_idx     = 0;
        frame_data = 0;
        frame_out  = 0;
      end else if (i_tvalid && o_tready) begin
        if (in_idx < 64) begin
          weights[in_idx] = ref_weight(i_tdata, in_idx);
        end else begin
          exp_q.push_back({i_tlast, ref_equalize(i_tdata, weights[in_idx % 64], OUT_SHIFT)});
          frame_data++;
        end
        in_idx++;
      end
      sof_prev = i_sof;
    end
  end

  // --------------------
  // Stimulus tasks
  // --------------------

  task automatic send_sample(input logic [31:0] d, input logic l);
    int  t;
    logic accepted;
    t        = 0;
    accepted = 1'b0;
    i_tdata  = d;
    i_tlast  = l;
    i_tvalid = 1'b1;
    while (!accepted && t < TIMEOUT) begin
      @(posedge clk_i);
      accepted = o_tready;
      t++;
    end
    #1;
    i_tvalid = 1'b0;
    if (!accepted) begin
      timeouts++;
      $display("Timeout: input sample was never accepted at %0t", $time);
    end
    if (($random(seed) % 4) == 0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Full-scale mode uses only the extreme component values
  function automatic logic [31:0] make_sample(input logic full_scale);
    logic [31:0] r;
    r = $random(seed);
    if (full_scale) begin
      r = {r[31] ? 16'h8000 : 16'h7FFF, r[15] ? 16'h8000 : 16'h7FFF};
    end
    return r;
  endfunction

  task automatic start_frame(input logic full_scale, input int n_syms);
    i_sof = 1'b1;
    @(posedge clk_i);
    #1;
    i_sof = 1'b0;
    for (int k = 0; k < 64; k++) begin
      send_sample(make_sample(full_scale), 1'b0);
    end
    for (int k = 0; k < n_syms * 64; k++) begin
      send_sample(make_sample(full_scale), (k % 64) == 63);
    end
  endtask

  task automatic drain_frame();
    int t;
    t = 0;
    while (exp_q.size() != 0 && t < TIMEOUT) begin
      @(posedge clk_i);
      t++;
    end
    #1;
    if (exp_q.size() != 0) begin
      timeouts++;
      $display("Timeout: %0d equalized samples never came out", exp_q.size());
    end
    assert (frame_out == frame_data)
    else begin
      errors++;
      $display("Fail at %0t: %0d outputs for %0d data samples", $time, frame_out, frame_data);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    rst_i       = 1'b1;
    i_sof       = 1'b0;
    i_tdata     = '0;
    i_tlast     = 1'b0;
    i_tvalid    = 1'b0;
    i_out_ready = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // Offered input must be ignored while idle
    check_idle = 1'b1;
    i_tvalid   = 1'b1;
    i_tdata    = $random(seed);
    repeat (10) @(posedge clk_i);
    #1;
    i_tvalid   = 1'b0;
    check_idle = 1'b0;

    start_frame(1'b0, 3);
    drain_frame();
    start_frame(1'b1, 2);
    drain_frame();
    stall_en = 1'b1;
    start_frame(1'b0, 4);
    drain_frame();
    // Restart while samples are still pending
    start_frame(1'b0, 1);
    start_frame(1'b0, 2);
    drain_frame();
    stall_en = 1'b0;

    $display("Errors: %0d value, %0d timeout, %0d protocol",
             errors, timeouts, dut0.u_sva.fail_count);
    if (errors == 0 && timeouts == 0 && dut0.u_sva.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+include
src/eq_pkg.sv
src/channel_estimator.sv
src/symbol_buffer.sv
src/weight_combiner.sv
src/one_tap_equalizer.sv
bench/one_tap_equalizer_sva.sv
bench/tb_one_tap_equalizer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the equalizer testbench with Verilator and runs it once.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_one_tap_equalizer -f build.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vtb_one_tap_equalizer)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
